// ==== logic/uart_link_pkg.sv ====
package uart_link_pkg;

    // serial timing
    localparam int CLKS_PER_BIT = 16;   // oversampling ratio, clocks per serial bit
    localparam int HOLD_CYCLES  = 64;   // link stays closed this long after reset

    typedef logic [7:0] byte_t;         // one data byte on the line

    // counter types sized from the timing constants
    typedef logic [$clog2(CLKS_PER_BIT)-1:0]  clk_cnt_t;
    typedef logic [$clog2(HOLD_CYCLES+1)-1:0] hold_cnt_t;
    typedef logic [3:0]                       bit_idx_t;   // start=0, data 1..8, parity, stop

    localparam clk_cnt_t  CLK_MID    = clk_cnt_t'(CLKS_PER_BIT / 2 - 1);  // middle of start bit
    localparam clk_cnt_t  CLK_LAST   = clk_cnt_t'(CLKS_PER_BIT - 1);      // last clock of a bit
    localparam hold_cnt_t HOLD_DONE  = hold_cnt_t'(HOLD_CYCLES);
    localparam bit_idx_t  BIT_PARITY = 4'd9;
    localparam bit_idx_t  BIT_STOP   = 4'd10;

    // command codes and the error reply
    localparam byte_t CMD_ON     = 8'hAA;
    localparam byte_t CMD_OFF    = 8'h55;
    localparam byte_t CMD_TOGGLE = 8'hC3;
    localparam byte_t NAK_BYTE   = 8'hFF;

    typedef struct packed {
        byte_t data;
        logic  parity_err;  // also set on a bad stop bit
    } rx_frame_t;

    // logical polarity, 1 = lit
    typedef struct packed {
        logic red;
        logic ready;
        logic err;
    } led_state_t;

    typedef enum logic [1:0] {
        IDLE,
        APPLY,
        WAIT_CREDIT,
        SEND
    } cmd_state_e;

endpackage

// ==== logic/uart_rx.sv ====
`timescale 1ns/1ps

module uart_rx (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rx,
    input  logic                   link_ready,
    input  logic                   frame_take,
    output uart_link_pkg::rx_frame_t frame,
    output logic                   frame_valid
);
    import uart_link_pkg::*;

    logic     rx_meta;      // first sync stage
    logic     rx_s;         // synchronized line
    logic     rx_prev;      // for falling edge detect
    logic     busy;
    bit_idx_t bit_idx;
    clk_cnt_t cyc_cnt;
    byte_t    shift;        // data bits with the lsb arriving first
    logic     par_bit;

    // two flop synchronizer plus edge history on an idle-high line
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_s    <= 1'b1;
            rx_prev <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_s    <= rx_meta;
            rx_prev <= rx_s;
        end
    end

    // bit sequencing control state
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy    <= 1'b0;
            bit_idx <= '0;
            cyc_cnt <= '0;
        end else if (!busy) begin
            if (link_ready && rx_prev && !rx_s) begin  // start edge is ignored while held
                busy    <= 1'b1;
                bit_idx <= '0;
                cyc_cnt <= '0;
            end
        end else if (bit_idx == '0) begin
            cyc_cnt <= cyc_cnt + 1'b1;
            if (cyc_cnt == CLK_MID) begin
                cyc_cnt <= '0;
                if (rx_s)
                    busy <= 1'b0;      // glitch and not a real start bit
                else
                    bit_idx <= bit_idx + 1'b1;
            end
        end else begin
            cyc_cnt <= cyc_cnt + 1'b1;
            if (cyc_cnt == CLK_LAST) begin  // mid-bit sample point
                cyc_cnt <= '0;
                bit_idx <= bit_idx + 1'b1;
                if (bit_idx == BIT_STOP)
                    busy <= 1'b0;
            end
        end
    end

    // sampled payload
    always_ff @(posedge clk) begin
        if (busy && bit_idx != '0 && cyc_cnt == CLK_LAST) begin
            if (bit_idx == BIT_PARITY)
                par_bit <= rx_s;
            else if (bit_idx != BIT_STOP)
                shift <= {rx_s, shift[7:1]};   // data bits 1..8
        end
    end

    wire stop_sample = busy && bit_idx == BIT_STOP && cyc_cnt == CLK_LAST;

    // holding register where a new frame overwrites an untaken one
    always_ff @(posedge clk) begin
        if (stop_sample) begin
            frame.data       <= shift;
            frame.parity_err <= (^{shift, par_bit}) | ~rx_s;  // odd count or framing error
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n)
            frame_valid <= 1'b0;
        else if (stop_sample)
            frame_valid <= 1'b1;           // new frame wins over a take
        else if (frame_take)
            frame_valid <= 1'b0;
    end

endmodule

// ==== logic/uart_tx.sv ====
`timescale 1ns/1ps

module uart_tx (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 tx_start,
    input  uart_link_pkg::byte_t tx_data,
    output logic                 tx,
    output logic                 credit_return
);
    import uart_link_pkg::*;

    logic       busy;
    bit_idx_t   bit_idx;    // bit now on the line
    clk_cnt_t   cyc_cnt;
    logic [9:0] shreg;      // remaining bits: data, parity, stop

    // control and line output
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy          <= 1'b0;
            bit_idx       <= '0;
            cyc_cnt       <= '0;
            tx            <= 1'b1;     // idle high
            credit_return <= 1'b0;
        end else begin
            credit_return <= 1'b0;     // one cycle pulse
            if (!busy) begin
                if (tx_start) begin
                    busy    <= 1'b1;
                    bit_idx <= '0;
                    cyc_cnt <= '0;
                    tx      <= 1'b0;   // start bit right away
                end
            end else begin
                cyc_cnt <= cyc_cnt + 1'b1;
                if (cyc_cnt == CLK_LAST) begin
                    cyc_cnt <= '0;
                    if (bit_idx == BIT_STOP) begin
                        busy          <= 1'b0;    // stop bit done, line free
                        credit_return <= 1'b1;
                    end else begin
                        tx      <= shreg[0];
                        bit_idx <= bit_idx + 1'b1;
                    end
                end
            end
        end
    end

    // frame payload, loaded on start and shifted per bit
    always_ff @(posedge clk) begin
        if (!busy && tx_start)
            shreg <= {1'b1, ^tx_data, tx_data};  // stop, even parity, data lsb first
        else if (busy && cyc_cnt == CLK_LAST)
            shreg <= {1'b1, shreg[9:1]};
    end

endmodule

// ==== logic/link_hold_timer.sv ====
`timescale 1ns/1ps

module link_hold_timer (
    input  logic clk,
    input  logic rst_n,
    output logic link_ready
);
    import uart_link_pkg::*;

    hold_cnt_t hold_cnt;

    // counts up from reset, then sticks at the end value
    always_ff @(posedge clk) begin
        if (!rst_n)
            hold_cnt <= '0;
        else if (hold_cnt != HOLD_DONE)
            hold_cnt <= hold_cnt + 1'b1;
    end

    assign link_ready = (hold_cnt == HOLD_DONE);   // low for HOLD_CYCLES after reset

endmodule

// ==== logic/cmd_ctrl.sv ====
`timescale 1ns/1ps

module cmd_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      link_ready,
    input  uart_link_pkg::rx_frame_t  frame,
    input  logic                      frame_valid,
    output logic                      frame_take,
    input  logic                      credit_return,
    output logic                      tx_start,
    output uart_link_pkg::byte_t      tx_data,
    output uart_link_pkg::led_state_t leds
);
    import uart_link_pkg::*;

    cmd_state_e state;
    rx_frame_t  cmd_q;      // frame being handled
    byte_t      reply_q;    // byte to send back
    logic       credit;     // single transmit credit
    logic       red_q;
    logic       err_q;
    logic       cmd_ok;

    // known code and clean parity
    assign cmd_ok = !cmd_q.parity_err &&
                    (cmd_q.data == CMD_ON || cmd_q.data == CMD_OFF ||
                     cmd_q.data == CMD_TOGGLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= IDLE;
            frame_take <= 1'b0;
            red_q      <= 1'b0;
            err_q      <= 1'b0;
        end else begin
            frame_take <= 1'b0;
            case (state)
                IDLE: begin
                    if (frame_valid && link_ready) begin
                        frame_take <= 1'b1;    // releases the rx holding register
                        state      <= APPLY;
                    end
                end
                APPLY: begin
                    if (cmd_ok) begin
                        err_q <= 1'b0;
                        case (cmd_q.data)
                            CMD_ON:  red_q <= 1'b1;
                            CMD_OFF: red_q <= 1'b0;
                            default: red_q <= ~red_q;   // toggle
                        endcase
                    end else begin
                        err_q <= 1'b1;         // red untouched
                    end
                    state <= credit ? SEND : WAIT_CREDIT;
                end
                WAIT_CREDIT: if (credit) state <= SEND;  // tx still busy with last reply
                SEND:        state <= IDLE;
                default:     state <= IDLE;
            endcase
        end
    end

    // payload capture
    always_ff @(posedge clk) begin
        if (state == IDLE && frame_valid)
            cmd_q <= frame;
        if (state == APPLY)
            reply_q <= cmd_ok ? cmd_q.data : NAK_BYTE;
    end

    // spent on send, restored when the stop bit ends
    always_ff @(posedge clk) begin
        if (!rst_n)
            credit <= 1'b1;
        else if (tx_start)
            credit <= 1'b0;
        else if (credit_return)
            credit <= 1'b1;
    end

    assign tx_start = (state == SEND);
    assign tx_data  = reply_q;

    assign leds.red   = red_q;
    assign leds.ready = link_ready;
    assign leds.err   = err_q;

endmodule

// ==== logic/uart_cmd_top.sv ====
`timescale 1ns/1ps

module uart_cmd_top (
    input  logic clk,
    input  logic rst_n,
    input  logic rx,
    output logic tx,
    output logic led_red,
    output logic led_green,
    output logic led_blue
);
    import uart_link_pkg::*;

    logic       link_ready;
    rx_frame_t  frame;
    logic       frame_valid;
    logic       frame_take;
    logic       tx_start;
    byte_t      tx_data;
    logic       credit_return;
    led_state_t leds;

    link_hold_timer i_link_hold_timer (
        .clk        (clk),
        .rst_n      (rst_n),
        .link_ready (link_ready)
    );

    uart_rx i_uart_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .rx          (rx),
        .link_ready  (link_ready),
        .frame_take  (frame_take),
        .frame       (frame),
        .frame_valid (frame_valid)
    );

    cmd_ctrl i_cmd_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .link_ready    (link_ready),
        .frame         (frame),
        .frame_valid   (frame_valid),
        .frame_take    (frame_take),
        .credit_return (credit_return),
        .tx_start      (tx_start),
        .tx_data       (tx_data),
        .leds          (leds)
    );

    uart_tx i_uart_tx (
        .clk           (clk),
        .rst_n         (rst_n),
        .tx_start      (tx_start),
        .tx_data       (tx_data),
        .tx            (tx),
        .credit_return (credit_return)
    );

    // board LEDs are active low
    assign led_red   = ~leds.red;
    assign led_green = ~leds.ready;
    assign led_blue  = ~leds.err;

endmodule

// ==== testbench/tb_uart_cmd_top.sv ====
`timescale 1ns/1ps

module tb_uart_cmd_top;
    import uart_link_pkg::*;

    localparam int FRAME_CYCLES = 11 * CLKS_PER_BIT;   // start, 8 data, parity, stop
    localparam int NUM_RANDOM   = 20;
    localparam int NUM_CMDS     = 7 + NUM_RANDOM;      // directed plus random
    // each command is one frame in and one reply out in just under two frame times
    // the hold frame and its quiet wait take three more plus some slack
    localparam int TIMEOUT_CYCLES = (2 * NUM_CMDS + 6) * FRAME_CYCLES + HOLD_CYCLES;

    logic clk;
    logic rst_n;
    logic rx;
    logic tx;
    logic led_red;
    logic led_green;
    logic led_blue;

    logic [8:0] replies[$];     // decoded replies as {parity, data}
    logic       model_red;      // expected LED state where 1 = lit
    logic       model_err;
    int         since_rst = 0;  // cycles since reset release
    int         cycle_cnt = 0;
    integer     seed;

    uart_cmd_top i_uart_cmd_top (
        .clk       (clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .tx        (tx),
        .led_red   (led_red),
        .led_green (led_green),
        .led_blue  (led_blue)
    );

    always #2 clk = ~clk;   // 4 ns period

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        assert (got === exp)
        else abort_run($sformatf("ERR %s got 0x%02h expected 0x%02h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else abort_run($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic check_true(input logic cond, input string msg);
        assert (cond)
        else abort_run(msg);
    endtask

    // one serial bit that changes just after the edge
    task automatic drive_bit(input logic b);
        rx = b;
        repeat (CLKS_PER_BIT) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input byte_t data, input logic bad_parity);
        @(posedge clk);
        #1;
        drive_bit(1'b0);                  // start
        for (int i = 0; i < 8; i++)
            drive_bit(data[i]);           // lsb first
        drive_bit(^data ^ bad_parity);    // even parity flipped on request
        drive_bit(1'b1);                  // stop
    endtask

    // update the model, send, wait for the reply and compare everything
    task automatic run_cmd(input byte_t data, input logic bad_parity);
        logic       known;
        byte_t      exp_reply;
        logic [8:0] got;
        known = (data == CMD_ON) || (data == CMD_OFF) || (data == CMD_TOGGLE);
        if (known && !bad_parity) begin
            exp_reply = data;             // echo
            model_err = 1'b0;
            if (data == CMD_ON)
                model_red = 1'b1;
            else if (data == CMD_OFF)
                model_red = 1'b0;
            else
                model_red = ~model_red;
        end else begin
            exp_reply = NAK_BYTE;
            model_err = 1'b1;             // red stays as it was
        end
        send_frame(data, bad_parity);
        while (replies.size() == 0)
            @(posedge clk);
        got = replies.pop_front();
        @(negedge clk);
        check_byte("reply", got[7:0], exp_reply);
        check_bit("reply_parity", got[8], ^exp_reply);
        check_bit("led_red", led_red, ~model_red);   // pins are active low
        check_bit("led_blue", led_blue, ~model_err);
        check_bit("led_green", led_green, 1'b0);
    endtask

    // cycle counters and run limit
    always @(posedge clk) begin
        if (rst_n)
            since_rst <= since_rst + 1;
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            abort_run($sformatf("timeout, run still going after %0d cycles", TIMEOUT_CYCLES));
    end

    // green off for exactly the hold time and lit from then on
    always @(negedge clk) begin
        if (rst_n)
            check_bit("led_green", led_green, since_rst < HOLD_CYCLES);
    end

    // host side receiver for the reply line
    initial begin : reply_decoder
        logic [8:0] bits;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge tx);
            repeat (CLKS_PER_BIT / 2) @(posedge clk);   // middle of start bit
            check_true(tx === 1'b0, "reply start bit did not stay low");
            for (int i = 0; i < 9; i++) begin
                repeat (CLKS_PER_BIT) @(posedge clk);
                bits[i] = tx;                           // data lsb first then parity
            end
            repeat (CLKS_PER_BIT) @(posedge clk);
            check_true(tx === 1'b1, "reply stop bit was not high");
            replies.push_back(bits);
        end
    end

    initial begin
        logic [31:0] rnd;
        byte_t       cmd;
        clk       = 1'b0;
        rst_n     = 1'b0;
        rx        = 1'b1;   // idle line
        model_red = 1'b0;
        model_err = 1'b0;
        seed      = 32'hfe12_84c6;
        repeat (10) @(posedge clk);
        #1 rst_n = 1'b1;

        // 0x00 has no falling edge after its start bit, so nothing is picked up once ready
        send_frame(8'h00, 1'b0);
        repeat (2 * FRAME_CYCLES) @(posedge clk);
        check_true(replies.size() == 0, "a reply came back for a frame sent during the hold");
        @(negedge clk);
        check_bit("led_green", led_green, 1'b0);
        check_bit("led_blue", led_blue, 1'b1);

        run_cmd(CMD_ON, 1'b0);
        run_cmd(CMD_OFF, 1'b0);
        run_cmd(CMD_TOGGLE, 1'b0);
        run_cmd(CMD_OFF, 1'b1);       // parity error keeps red as it was
        run_cmd(CMD_OFF, 1'b0);       // same code with clean parity clears blue
        run_cmd(8'h12, 1'b0);         // unknown code lights blue from off
        run_cmd(CMD_TOGGLE, 1'b0);    // clears blue again

        for (int i = 0; i < NUM_RANDOM; i++) begin
            rnd = $random(seed);
            case (rnd[9:8])
                2'd0:    cmd = CMD_ON;
                2'd1:    cmd = CMD_OFF;
                2'd2:    cmd = CMD_TOGGLE;
                default: cmd = rnd[7:0];   // mostly unknown codes
            endcase
            run_cmd(cmd, rnd[15:13] == 3'd0);   // occasional bad parity
        end

        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== filelist.f ====
logic/uart_link_pkg.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/link_hold_timer.sv
logic/cmd_ctrl.sv
logic/uart_cmd_top.sv
testbench/tb_uart_cmd_top.sv

// ==== Makefile ====
TOP := tb_uart_cmd_top

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f filelist.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log; grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
